// ==== noc_pkg.sv ====
// mesh network definitions for the pod array
// covers the array size, the packet layout and the router port indices
package noc_pkg;

  // array shape
  localparam int num_pods_x_lp = 2;
  localparam int num_pods_y_lp = 2;

  // 0 and 3 are the edge coordinates and pods sit at 1..2
  localparam int cord_width_lp = 2;

  // msb to lsb a packet holds dest_x, dest_y, src_x, src_y and payload
  localparam int payload_width_lp = 16;
  localparam int packet_width_lp  = 4 * cord_width_lp + payload_width_lp;

  localparam int payload_lsb_lp = 0;
  localparam int src_y_lsb_lp   = payload_lsb_lp + payload_width_lp;
  localparam int src_x_lsb_lp   = src_y_lsb_lp + cord_width_lp;
  localparam int dest_y_lsb_lp  = src_x_lsb_lp + cord_width_lp;
  localparam int dest_x_lsb_lp  = dest_y_lsb_lp + cord_width_lp;

  // router port indices
  localparam int num_dirs_lp  = 5;
  localparam int dir_width_lp = 3;

  localparam logic [dir_width_lp-1:0] dir_p_lp = 3'd0;
  localparam logic [dir_width_lp-1:0] dir_w_lp = 3'd1;
  localparam logic [dir_width_lp-1:0] dir_e_lp = 3'd2;
  localparam logic [dir_width_lp-1:0] dir_n_lp = 3'd3;
  localparam logic [dir_width_lp-1:0] dir_s_lp = 3'd4;

  // input buffer depth per router port is kept a power of two
  localparam int fifo_depth_lp     = 2;
  localparam int fifo_ptr_width_lp = $clog2(fifo_depth_lp);
  localparam int fifo_cnt_width_lp = $clog2(fifo_depth_lp + 1);

endpackage

// ==== pod_array.f ====
noc_pkg.sv
tag_pkg.sv
pod_tag_client.sv
pod_input_fifo.sv
pod_router.sv
pod_row.sv
pod_array.sv
pod_array_properties.sv
pod_array_checker.sv
pod_array_tb.sv

// ==== pod_array.sv ====
// pod array top level
// one reset client per pod, one row per array row, vertical links stitched between rows
module pod_array import noc_pkg::*; (
  input  logic                                                         clk_i,
  input  logic                                                         arst_n_i,
  input  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                  tag_valid_i,
  input  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                  tag_data_i,
  // horizontal edges per row
  input  logic [num_pods_y_lp-1:0]                                     west_v_i,
  input  logic [num_pods_y_lp-1:0][packet_width_lp-1:0]                west_data_i,
  output logic [num_pods_y_lp-1:0]                                     west_v_o,
  output logic [num_pods_y_lp-1:0][packet_width_lp-1:0]                west_data_o,
  input  logic [num_pods_y_lp-1:0]                                     east_v_i,
  input  logic [num_pods_y_lp-1:0][packet_width_lp-1:0]                east_data_i,
  output logic [num_pods_y_lp-1:0]                                     east_v_o,
  output logic [num_pods_y_lp-1:0][packet_width_lp-1:0]                east_data_o,
  // vertical edges per column
  input  logic [num_pods_x_lp-1:0]                                     north_v_i,
  input  logic [num_pods_x_lp-1:0][packet_width_lp-1:0]                north_data_i,
  output logic [num_pods_x_lp-1:0]                                     north_v_o,
  output logic [num_pods_x_lp-1:0][packet_width_lp-1:0]                north_data_o,
  input  logic [num_pods_x_lp-1:0]                                     south_v_i,
  input  logic [num_pods_x_lp-1:0][packet_width_lp-1:0]                south_data_i,
  output logic [num_pods_x_lp-1:0]                                     south_v_o,
  output logic [num_pods_x_lp-1:0][packet_width_lp-1:0]                south_data_o,
  // local ports per pod
  input  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                  inject_v_i,
  input  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] inject_data_i,
  output logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                  eject_v_o,
  output logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] eject_data_o
);

  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                      pod_reset;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                      row_n_v_li;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] row_n_data_li;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                      row_n_v_lo;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] row_n_data_lo;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                      row_s_v_li;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] row_s_data_li;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                      row_s_v_lo;
  logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] row_s_data_lo;

  for (genvar y = 0; y < num_pods_y_lp; y++) begin : g_row
    for (genvar x = 0; x < num_pods_x_lp; x++) begin : g_pod
      pod_tag_client u_tag (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .tag_valid_i (tag_valid_i[y][x]),
        .tag_data_i  (tag_data_i[y][x]),
        .pod_reset_o (pod_reset[y][x])
      );
    end

    pod_row #(.row_index_p(y)) u_row (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .pod_reset_i   (pod_reset[y]),
      .west_v_i      (west_v_i[y]),
      .west_data_i   (west_data_i[y]),
      .west_v_o      (west_v_o[y]),
      .west_data_o   (west_data_o[y]),
      .east_v_i      (east_v_i[y]),
      .east_data_i   (east_data_i[y]),
      .east_v_o      (east_v_o[y]),
      .east_data_o   (east_data_o[y]),
      .north_v_i     (row_n_v_li[y]),
      .north_data_i  (row_n_data_li[y]),
      .north_v_o     (row_n_v_lo[y]),
      .north_data_o  (row_n_data_lo[y]),
      .south_v_i     (row_s_v_li[y]),
      .south_data_i  (row_s_data_li[y]),
      .south_v_o     (row_s_v_lo[y]),
      .south_data_o  (row_s_data_lo[y]),
      .inject_v_i    (inject_v_i[y]),
      .inject_data_i (inject_data_i[y]),
      .eject_v_o     (eject_v_o[y]),
      .eject_data_o  (eject_data_o[y])
    );

    // top row faces the north edge, lower rows take the row above
    if (y == 0) begin : g_north_edge
      assign row_n_v_li[y]    = north_v_i;
      assign row_n_data_li[y] = north_data_i;
      assign north_v_o        = row_n_v_lo[y];
      assign north_data_o     = row_n_data_lo[y];
    end else begin : g_stitch
      assign row_n_v_li[y]      = row_s_v_lo[y-1];
      assign row_n_data_li[y]   = row_s_data_lo[y-1];
      assign row_s_v_li[y-1]    = row_n_v_lo[y];
      assign row_s_data_li[y-1] = row_n_data_lo[y];
    end

    if (y == num_pods_y_lp - 1) begin : g_south_edge
      assign row_s_v_li[y]    = south_v_i;
      assign row_s_data_li[y] = south_data_i;
      assign south_v_o        = row_s_v_lo[y];
      assign south_data_o     = row_s_data_lo[y];
    end
  end

endmodule

// ==== pod_array_checker.sv ====
// output checker for the pod array
// matches every output packet against the expected set, any order, one line per test
module pod_array_checker import noc_pkg::*; (
  input logic                                                             clk_i,
  input logic                                                             arst_n_i,
  input logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0]                      eject_v_i,
  input logic [num_pods_y_lp-1:0][num_pods_x_lp-1:0][packet_width_lp-1:0] eject_data_i,
  input logic [num_pods_y_lp-1:0]                                         west_v_i,
  input logic [num_pods_y_lp-1:0][packet_width_lp-1:0]                    west_data_i,
  input logic [num_pods_y_lp-1:0]                                         east_v_i,
  input logic [num_pods_y_lp-1:0][packet_width_lp-1:0]                    east_data_i,
  input logic [num_pods_x_lp-1:0]                                         north_v_i,
  input logic [num_pods_x_lp-1:0][packet_width_lp-1:0]                    north_data_i,
  input logic [num_pods_x_lp-1:0]                                         south_v_i,
  input logic [num_pods_x_lp-1:0][packet_width_lp-1:0]                    south_data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int                         exp_port[$];
  logic [packet_width_lp-1:0] exp_pkt[$];
  int                         err_count = 0;
  int                         test_count = 0;
  logic [11:0]                       out_v;
  logic [11:0][packet_width_lp-1:0]  out_data;

  // port ids 0..3 are eject, 4..5 west, 6..7 east, 8..9 north and 10..11 south
  always_comb begin
    out_v    = {south_v_i, north_v_i, east_v_i, west_v_i, eject_v_i};
    out_data = {south_data_i, north_data_i, east_data_i, west_data_i, eject_data_i};
  end

  function automatic string port_name(input int p);
    if (p < 4) return $sformatf("eject_data_o[%0d][%0d]", p / 2, p % 2);
    if (p < 6) return $sformatf("west_data_o[%0d]", p - 4);
    if (p < 8) return $sformatf("east_data_o[%0d]", p - 6);
    if (p < 10) return $sformatf("north_data_o[%0d]", p - 8);
    return $sformatf("south_data_o[%0d]", p - 10);
  endfunction

  task automatic expect_pkt(input int port, input logic [packet_width_lp-1:0] pkt);
    exp_port.push_back(port);
    exp_pkt.push_back(pkt);
  endtask

  task automatic match_arrival(input int port, input logic [packet_width_lp-1:0] pkt);
    int same_port;
    same_port = -1;
    for (int i = 0; i < exp_port.size(); i++) begin
      if (exp_port[i] == port && exp_pkt[i] == pkt) begin
        exp_port.delete(i);
        exp_pkt.delete(i);
        return;
      end
      if (exp_port[i] == port && same_port < 0) same_port = i;
    end
    err_count++;
    if (same_port >= 0) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, port_name(port),
               exp_pkt[same_port], pkt);
      exp_port.delete(same_port);
      exp_pkt.delete(same_port);
    end else begin
      $display("unexpected packet %h appeared on %s at %0t", pkt, port_name(port), $time);
    end
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      for (int p = 0; p < 12; p++) begin
        if (out_v[p]) match_arrival(p, out_data[p]);
      end
    end
  end

  task automatic run_test(input string name, input int min_cycles, input int max_cycles);
    int waited;
    int start_errs;
    waited     = 0;
    start_errs = err_count;
    while (waited < max_cycles && (waited < min_cycles || exp_port.size() != 0)) begin
      @(posedge clk_i);
      waited++;
    end
    for (int i = 0; i < exp_port.size(); i++) begin
      $display("packet %h never arrived on %s", exp_pkt[i], port_name(exp_port[i]));
      err_count++;
    end
    exp_port.delete();
    exp_pkt.delete();
    test_count++;
    $display("test %-16s %s (%0d errors)", name,
             (err_count == start_errs) ? "ok" : "bad", err_count - start_errs);
  endtask

endmodule

// ==== pod_array_properties.sv ====
// bound checks on link strobes
// a strobe never fires while its gate is busy, and back to back strobes carry new packets
module pod_array_properties import noc_pkg::*; #(
  parameter int width_p = 1
) (
  input logic                                    clk_i,
  input logic                                    arst_n_i,
  input logic [width_p-1:0]                      busy_i,
  input logic [width_p-1:0]                      v_i,
  input logic [width_p-1:0][packet_width_lp-1:0] data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  for (genvar k = 0; k < width_p; k++) begin : g_lane
    // busy is fifo full for fifos and the pod reset at the top level
    a_no_strobe_when_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(v_i[k] && busy_i[k]))
      else $error("strobe %0d raised while busy", k);

    // a held strobe means a second packet, never a repeat of the first
    a_one_cycle_per_packet : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (v_i[k] && $past(v_i[k])) |-> (data_i[k] != $past(data_i[k])))
      else $error("strobe %0d held with the same packet", k);
  end

endmodule

bind pod_input_fifo pod_array_properties #(.width_p(1)) u_fifo_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .busy_i   (full),
  .v_i      (wr_v_i),
  .data_i   (wr_data_i)
);

bind pod_array pod_array_properties #(.width_p(4)) u_array_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .busy_i   (pod_reset),
  .v_i      (eject_v_o),
  .data_i   (eject_data_o)
);

// ==== pod_array_tb.sv ====
// testbench for the pod array
// releases pods by tag frames, then runs a table of routed packets through the mesh
module pod_array_tb import noc_pkg::*, tag_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  logic                                 clk_i;
  logic                                 arst_n_i;
  logic [1:0][1:0]                      tag_valid_i;
  logic [1:0][1:0]                      tag_data_i;
  logic [1:0][1:0]                      inject_v_i;
  logic [1:0][1:0][packet_width_lp-1:0] inject_data_i;
  logic [1:0][1:0]                      eject_v_o;
  logic [1:0][1:0][packet_width_lp-1:0] eject_data_o;
  logic [1:0]                           west_v_i;
  logic [1:0][packet_width_lp-1:0]      west_data_i;
  logic [1:0]                           west_v_o;
  logic [1:0][packet_width_lp-1:0]      west_data_o;
  logic [1:0]                           east_v_i;
  logic [1:0][packet_width_lp-1:0]      east_data_i;
  logic [1:0]                           east_v_o;
  logic [1:0][packet_width_lp-1:0]      east_data_o;
  logic [1:0]                           north_v_i;
  logic [1:0][packet_width_lp-1:0]      north_data_i;
  logic [1:0]                           north_v_o;
  logic [1:0][packet_width_lp-1:0]      north_data_o;
  logic [1:0]                           south_v_i;
  logic [1:0][packet_width_lp-1:0]      south_data_i;
  logic [1:0]                           south_v_o;
  logic [1:0][packet_width_lp-1:0]      south_data_o;

  logic [31:0] rng = 32'h457d;
  string       test_names[$];
  int          t_test[$];
  int          t_src[$];
  int          t_dx[$];
  int          t_dy[$];

  pod_array u_pod_array (.*);

  pod_array_checker u_checker (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .eject_v_i    (eject_v_o),
    .eject_data_i (eject_data_o),
    .west_v_i     (west_v_o),
    .west_data_i  (west_data_o),
    .east_v_i     (east_v_o),
    .east_data_i  (east_data_o),
    .north_v_i    (north_v_o),
    .north_data_i (north_data_o),
    .south_v_i    (south_v_o),
    .south_data_i (south_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // global coordinates of the router that a source port feeds
  function automatic void entry_pos(input int src, output int x, output int y);
    if (src < 4) begin
      x = src % 2 + 1;
      y = src / 2 + 1;
    end else if (src < 6) begin
      x = 1;
      y = src - 3;
    end else if (src < 8) begin
      x = 2;
      y = src - 5;
    end else if (src < 10) begin
      x = src - 7;
      y = 1;
    end else begin
      x = src - 9;
      y = 2;
    end
  endfunction

  // walk the mesh x first, then y, until the packet leaves
  function automatic int exit_port(input int src, input int dx, input int dy);
    int x;
    int y;
    entry_pos(src, x, y);
    for (int step = 0; step < 8; step++) begin
      if (dx < x) begin
        if (x == 1) return 4 + y - 1;
        x--;
      end else if (dx > x) begin
        if (x == 2) return 6 + y - 1;
        x++;
      end else if (dy < y) begin
        if (y == 1) return 8 + x - 1;
        y--;
      end else if (dy > y) begin
        if (y == 2) return 10 + x - 1;
        y++;
      end else begin
        return (y - 1) * 2 + x - 1;
      end
    end
    return -1;
  endfunction

  task automatic drive_src(input int src, input logic v, input logic [packet_width_lp-1:0] pkt);
    if (src < 4) begin
      inject_v_i[src/2][src%2] = v;
      inject_data_i[src/2][src%2] = pkt;
    end else if (src < 6) begin
      west_v_i[src-4] = v;
      west_data_i[src-4] = pkt;
    end else if (src < 8) begin
      east_v_i[src-6] = v;
      east_data_i[src-6] = pkt;
    end else if (src < 10) begin
      north_v_i[src-8] = v;
      north_data_i[src-8] = pkt;
    end else begin
      south_v_i[src-10] = v;
      south_data_i[src-10] = pkt;
    end
  endtask

  // one packet per listed source and all in the same cycle
  task automatic send_batch(input int srcs[$], input int dxs[$], input int dys[$],
                            input bit expect_out);
    int x;
    int y;
    logic [packet_width_lp-1:0] pkt;
    @(negedge clk_i);
    for (int i = 0; i < srcs.size(); i++) begin
      rng = xorshift(rng);
      entry_pos(srcs[i], x, y);
      pkt = {2'(dxs[i]), 2'(dys[i]), 2'(x), 2'(y), rng[15:0]};
      drive_src(srcs[i], 1'b1, pkt);
      if (expect_out) u_checker.expect_pkt(exit_port(srcs[i], dxs[i], dys[i]), pkt);
    end
    @(negedge clk_i);
    for (int i = 0; i < srcs.size(); i++) drive_src(srcs[i], 1'b0, '0);
  endtask

  task automatic send_frame(input int pod, input logic [tag_frame_len_lp-1:0] frame);
    for (int b = 0; b < tag_frame_len_lp; b++) begin
      @(negedge clk_i);
      tag_valid_i[pod/2][pod%2] = 1'b1;
      tag_data_i[pod/2][pod%2]  = frame[b];
    end
    @(negedge clk_i);
    tag_valid_i[pod/2][pod%2] = 1'b0;
    repeat (reset_depth_lp + 2) @(negedge clk_i);
  endtask

  // adds a packet to the most recently named test
  task automatic add_entry(input int src, input int dx, input int dy);
    t_test.push_back(test_names.size() - 1);
    t_src.push_back(src);
    t_dx.push_back(dx);
    t_dy.push_back(dy);
  endtask

  task automatic add_test(input string name, input int src, input int dx, input int dy);
    test_names.push_back(name);
    add_entry(src, dx, dy);
  endtask

  task automatic build_table();
    for (int s = 0; s < 4; s++) begin
      for (int d = 0; d < 4; d++) begin
        add_test($sformatf("local_%0d_to_%0d", s, d), s, d % 2 + 1, d / 2 + 1);
      end
    end
    add_test("west_in", 4, 2, 2);
    add_test("east_in", 7, 1, 1);
    add_test("north_in", 8, 2, 2);
    add_test("south_in", 11, 1, 1);
    add_test("to_west", 1, 0, 1);
    add_test("to_east", 2, 3, 2);
    add_test("to_north", 3, 2, 0);
    add_test("to_south", 0, 1, 3);
    add_test("pass_through", 5, 3, 2);
    // three pods race for the eject of pod 1
    add_test("contention", 0, 2, 1);
    add_entry(3, 2, 1);
    add_entry(1, 2, 1);
  endtask

  initial begin
    repeat (20000) @(posedge clk_i);
    $display("simulation timed out");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int srcs[$];
    int dxs[$];
    int dys[$];
    arst_n_i      = 1'b0;
    tag_valid_i   = '0;
    tag_data_i    = '0;
    inject_v_i    = '0;
    inject_data_i = '0;
    west_v_i      = '0;
    west_data_i   = '0;
    east_v_i      = '0;
    east_data_i   = '0;
    north_v_i     = '0;
    north_data_i  = '0;
    south_v_i     = '0;
    south_data_i  = '0;
    build_table();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // every pod is still held so nothing may come out
    send_batch('{0, 3}, '{2, 1}, '{2, 1}, 1'b0);
    u_checker.run_test("reset_hold", 40, 40);

    // frame bit 0 is the reset value and bits 3..1 hold the key
    for (int p = 0; p < 3; p++) send_frame(p, 4'b1010);
    send_frame(3, 4'b0110);
    send_batch('{3}, '{2}, '{2}, 1'b0);
    u_checker.run_test("bad_key", 40, 40);
    send_frame(3, 4'b1010);

    for (int t = 0; t < test_names.size(); t++) begin
      srcs.delete();
      dxs.delete();
      dys.delete();
      for (int i = 0; i < t_test.size(); i++) begin
        if (t_test[i] == t) begin
          srcs.push_back(t_src[i]);
          dxs.push_back(t_dx[i]);
          dys.push_back(t_dy[i]);
        end
      end
      send_batch(srcs, dxs, dys, 1'b1);
      u_checker.run_test(test_names[t], 0, 60);
    end

    repeat (10) @(posedge clk_i);
    $display("tests run %0d, errors %0d", u_checker.test_count, u_checker.err_count);
    if (u_checker.err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== pod_input_fifo.sv ====
// small packet buffer on one router input
// drops writes while full, emptied by the pod reset
module pod_input_fifo import noc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       pod_reset_i,
  input  logic                       wr_v_i,
  input  logic [packet_width_lp-1:0] wr_data_i,
  input  logic                       rd_yumi_i,
  output logic                       rd_v_o,
  output logic [packet_width_lp-1:0] rd_data_o
);

  logic [packet_width_lp-1:0]   mem_r [fifo_depth_lp];
  logic [fifo_ptr_width_lp-1:0] wr_ptr_r;
  logic [fifo_ptr_width_lp-1:0] rd_ptr_r;
  logic [fifo_cnt_width_lp-1:0] count_r;
  logic                         full;
  logic                         do_wr;
  logic                         do_rd;

  assign full      = (count_r == fifo_cnt_width_lp'(fifo_depth_lp));
  assign do_wr     = wr_v_i && !full && !pod_reset_i;
  assign do_rd     = rd_yumi_i && rd_v_o;
  assign rd_v_o    = (count_r != '0);
  assign rd_data_o = mem_r[rd_ptr_r];

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else if (pod_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (do_wr) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (do_rd) rd_ptr_r <= rd_ptr_r + 1'b1;
      count_r <= count_r + fifo_cnt_width_lp'(do_wr) - fifo_cnt_width_lp'(do_rd);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) mem_r[wr_ptr_r] <= wr_data_i;
  end

endmodule

// ==== pod_router.sv ====
// five port pod router, dimension order routing with x resolved first
// each output has its own round robin arbiter and a registered output
module pod_router import noc_pkg::*; (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        pod_reset_i,
  input  logic [cord_width_lp-1:0]                    my_x_i,
  input  logic [cord_width_lp-1:0]                    my_y_i,
  input  logic [num_dirs_lp-1:0]                      in_v_i,
  input  logic [num_dirs_lp-1:0][packet_width_lp-1:0] in_data_i,
  output logic [num_dirs_lp-1:0]                      out_v_o,
  output logic [num_dirs_lp-1:0][packet_width_lp-1:0] out_data_o
);

  logic [num_dirs_lp-1:0]                      head_v;
  logic [num_dirs_lp-1:0][packet_width_lp-1:0] head_data;
  logic [num_dirs_lp-1:0][dir_width_lp-1:0]    head_dir;
  logic [num_dirs_lp-1:0]                      head_yumi;
  // indexed as [output][input]
  logic [num_dirs_lp-1:0][num_dirs_lp-1:0]     req;
  logic [num_dirs_lp-1:0]                      grant_v;
  logic [num_dirs_lp-1:0][dir_width_lp-1:0]    grant_idx;
  logic [num_dirs_lp-1:0][dir_width_lp-1:0]    last_r;

  function automatic logic [dir_width_lp-1:0] route_dir(
    input logic [packet_width_lp-1:0] pkt,
    input logic [cord_width_lp-1:0]   x,
    input logic [cord_width_lp-1:0]   y
  );
    logic [cord_width_lp-1:0] dx;
    logic [cord_width_lp-1:0] dy;
    dx = pkt[dest_x_lsb_lp +: cord_width_lp];
    dy = pkt[dest_y_lsb_lp +: cord_width_lp];
    if (dx < x) return dir_w_lp;
    if (dx > x) return dir_e_lp;
    if (dy < y) return dir_n_lp;
    if (dy > y) return dir_s_lp;
    return dir_p_lp;
  endfunction

  for (genvar i = 0; i < num_dirs_lp; i++) begin : g_in
    pod_input_fifo u_fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .pod_reset_i (pod_reset_i),
      .wr_v_i      (in_v_i[i]),
      .wr_data_i   (in_data_i[i]),
      .rd_yumi_i   (head_yumi[i]),
      .rd_v_o      (head_v[i]),
      .rd_data_o   (head_data[i])
    );

    assign head_dir[i] = route_dir(head_data[i], my_x_i, my_y_i);
  end

  always_comb begin
    for (int o = 0; o < num_dirs_lp; o++) begin
      for (int i = 0; i < num_dirs_lp; i++) begin
        req[o][i] = head_v[i] && (head_dir[i] == dir_width_lp'(o));
      end
    end
  end

  always_comb begin : arb
    int idx;
    grant_v   = '0;
    grant_idx = last_r;
    for (int o = 0; o < num_dirs_lp; o++) begin
      // scan backward so the first requester after the last grant wins
      for (int k = num_dirs_lp; k >= 1; k--) begin
        idx = (int'(last_r[o]) + k) % num_dirs_lp;
        if (req[o][idx]) begin
          grant_v[o]   = 1'b1;
          grant_idx[o] = dir_width_lp'(idx);
        end
      end
    end
  end

  // an input asks for one output only, so at most one grant pops it
  always_comb begin
    head_yumi = '0;
    for (int o = 0; o < num_dirs_lp; o++) begin
      if (grant_v[o]) head_yumi[grant_idx[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_v_o <= '0;
      last_r  <= '0;
    end else if (pod_reset_i) begin
      out_v_o <= '0;
      last_r  <= '0;
    end else begin
      out_v_o <= grant_v;
      for (int o = 0; o < num_dirs_lp; o++) begin
        if (grant_v[o]) last_r[o] <= grant_idx[o];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < num_dirs_lp; o++) begin
      if (grant_v[o]) out_data_o[o] <= head_data[grant_idx[o]];
    end
  end

endmodule

// ==== pod_row.sv ====
// one row of pod routers linked east to west
// assigns each router its global coordinates and exposes the remaining links
module pod_row import noc_pkg::*; #(
  parameter int row_index_p = 0
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic [num_pods_x_lp-1:0]                      pod_reset_i,
  input  logic                                          west_v_i,
  input  logic [packet_width_lp-1:0]                    west_data_i,
  output logic                                          west_v_o,
  output logic [packet_width_lp-1:0]                    west_data_o,
  input  logic                                          east_v_i,
  input  logic [packet_width_lp-1:0]                    east_data_i,
  output logic                                          east_v_o,
  output logic [packet_width_lp-1:0]                    east_data_o,
  // per column vertical links
  input  logic [num_pods_x_lp-1:0]                      north_v_i,
  input  logic [num_pods_x_lp-1:0][packet_width_lp-1:0] north_data_i,
  output logic [num_pods_x_lp-1:0]                      north_v_o,
  output logic [num_pods_x_lp-1:0][packet_width_lp-1:0] north_data_o,
  input  logic [num_pods_x_lp-1:0]                      south_v_i,
  input  logic [num_pods_x_lp-1:0][packet_width_lp-1:0] south_data_i,
  output logic [num_pods_x_lp-1:0]                      south_v_o,
  output logic [num_pods_x_lp-1:0][packet_width_lp-1:0] south_data_o,
  // local ports
  input  logic [num_pods_x_lp-1:0]                      inject_v_i,
  input  logic [num_pods_x_lp-1:0][packet_width_lp-1:0] inject_data_i,
  output logic [num_pods_x_lp-1:0]                      eject_v_o,
  output logic [num_pods_x_lp-1:0][packet_width_lp-1:0] eject_data_o
);

  logic [num_pods_x_lp-1:0][num_dirs_lp-1:0]                      rtr_in_v;
  logic [num_pods_x_lp-1:0][num_dirs_lp-1:0][packet_width_lp-1:0] rtr_in_data;
  logic [num_pods_x_lp-1:0][num_dirs_lp-1:0]                      rtr_out_v;
  logic [num_pods_x_lp-1:0][num_dirs_lp-1:0][packet_width_lp-1:0] rtr_out_data;
  logic [num_pods_x_lp-1:0][cord_width_lp-1:0]                    global_x;
  logic [num_pods_x_lp-1:0][cord_width_lp-1:0]                    global_y;

  for (genvar x = 0; x < num_pods_x_lp; x++) begin : g_col
    // coordinate 0 is the west and north edge, pods start at 1
    assign global_x[x] = cord_width_lp'(x + 1);
    assign global_y[x] = cord_width_lp'(row_index_p + 1);

    pod_router u_router (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .pod_reset_i (pod_reset_i[x]),
      .my_x_i      (global_x[x]),
      .my_y_i      (global_y[x]),
      .in_v_i      (rtr_in_v[x]),
      .in_data_i   (rtr_in_data[x]),
      .out_v_o     (rtr_out_v[x]),
      .out_data_o  (rtr_out_data[x])
    );

    assign rtr_in_v[x][dir_p_lp]    = inject_v_i[x];
    assign rtr_in_data[x][dir_p_lp] = inject_data_i[x];
    assign eject_v_o[x]             = rtr_out_v[x][dir_p_lp];
    assign eject_data_o[x]          = rtr_out_data[x][dir_p_lp];

    assign rtr_in_v[x][dir_n_lp]    = north_v_i[x];
    assign rtr_in_data[x][dir_n_lp] = north_data_i[x];
    assign north_v_o[x]             = rtr_out_v[x][dir_n_lp];
    assign north_data_o[x]          = rtr_out_data[x][dir_n_lp];
    assign rtr_in_v[x][dir_s_lp]    = south_v_i[x];
    assign rtr_in_data[x][dir_s_lp] = south_data_i[x];
    assign south_v_o[x]             = rtr_out_v[x][dir_s_lp];
    assign south_data_o[x]          = rtr_out_data[x][dir_s_lp];

    if (x == 0) begin : g_west_edge
      assign rtr_in_v[x][dir_w_lp]    = west_v_i;
      assign rtr_in_data[x][dir_w_lp] = west_data_i;
      assign west_v_o                 = rtr_out_v[x][dir_w_lp];
      assign west_data_o              = rtr_out_data[x][dir_w_lp];
    end else begin : g_west_link
      assign rtr_in_v[x][dir_w_lp]    = rtr_out_v[x-1][dir_e_lp];
      assign rtr_in_data[x][dir_w_lp] = rtr_out_data[x-1][dir_e_lp];
    end

    if (x == num_pods_x_lp - 1) begin : g_east_edge
      assign rtr_in_v[x][dir_e_lp]    = east_v_i;
      assign rtr_in_data[x][dir_e_lp] = east_data_i;
      assign east_v_o                 = rtr_out_v[x][dir_e_lp];
      assign east_data_o              = rtr_out_data[x][dir_e_lp];
    end else begin : g_east_link
      assign rtr_in_v[x][dir_e_lp]    = rtr_out_v[x+1][dir_w_lp];
      assign rtr_in_data[x][dir_e_lp] = rtr_out_data[x+1][dir_w_lp];
    end
  end

endmodule

// ==== pod_tag_client.sv ====
// pod reset client
// receives a serial key frame and drives the pod reset through a short chain
module pod_tag_client import tag_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic tag_valid_i,
  input  logic tag_data_i,
  output logic pod_reset_o
);

  logic [tag_frame_len_lp-1:0]   frame_r;
  logic [tag_frame_len_lp-1:0]   frame_next;
  logic [tag_count_width_lp-1:0] count_r;
  logic                          frame_done;
  logic                          key_ok;
  logic [reset_depth_lp-1:0]     reset_chain_r;

  // lsb arrives first, so each new bit enters at the top
  assign frame_next = {tag_data_i, frame_r[tag_frame_len_lp-1:1]};
  assign frame_done = tag_valid_i &&
                      (count_r == tag_count_width_lp'(tag_frame_len_lp - 1));
  assign key_ok     = (frame_next[tag_frame_len_lp-1:1] == tag_key_lp);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_r <= '0;
      count_r <= '0;
    end else if (tag_valid_i) begin
      frame_r <= frame_next;
      count_r <= frame_done ? '0 : count_r + 1'b1;
    end
  end

  // pods come out of reset held, stage 0 keeps the last accepted request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reset_chain_r <= '1;
    end else begin
      if (frame_done && key_ok) begin
        reset_chain_r[0] <= frame_next[tag_reset_bit_lp];
      end
      reset_chain_r[reset_depth_lp-1:1] <= reset_chain_r[reset_depth_lp-2:0];
    end
  end

  assign pod_reset_o = reset_chain_r[reset_depth_lp-1];

endmodule

// ==== tag_pkg.sv ====
// serial reset frame definitions for the pod tag clients
package tag_pkg;

  // frame is sent lsb first
  localparam int tag_frame_len_lp   = 4;
  localparam int tag_count_width_lp = $clog2(tag_frame_len_lp);

  // key sits in frame bits 3 down to 1
  localparam logic [tag_frame_len_lp-2:0] tag_key_lp = 3'b101;

  // requested reset value
  localparam int tag_reset_bit_lp = 0;

  // register stages from frame completion to the pod reset change
  localparam int reset_depth_lp = 3;

endpackage
